// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= gpio_bus_slave_tb
RTL_TOP   ?= gpio_bus_slave
FILELIST  ?= sources.f
RTL_SRCS  ?= $(filter rtl/%,$(shell cat $(FILELIST)))
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test passed" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== rtl/bus_response_regs.sv ====
module bus_response_regs (
	input  logic                      BUS,
	input  logic                      reset,
	input  logic                      done,
	input  logic                      rnw,
	input  gpio_bus_pkg::region_t     region,
	input  gpio_bus_pkg::word_index_t word_index,
	input  gpio_bus_pkg::data_t       gpo_word,
	input  gpio_bus_pkg::gpio_vec_t   gp_ip,
	output gpio_bus_pkg::data_t       read_data,
	output logic                      error
);
	import gpio_bus_pkg::*;

	logic  read_err;
	logic  write_err;
	logic  read_ok;
	data_t gpi_word;
	data_t read_sel;

	//////////////////////////////////////////////////////////////////////
	// Decode of the response

	assign read_err  = rnw && (region == REGION_NONE);
	assign write_err = !rnw && (region != REGION_GPO); // Input bank is read only
	assign read_ok   = rnw && (region != REGION_NONE);

	assign gpi_word = gp_ip[word_index*DATA_W +: DATA_W];

	// Output bank or input bank
	assign read_sel = (region == REGION_GPO) ? gpo_word : gpi_word;

	//////////////////////////////////////////////////////////////////////
	// Response registers

	always_ff @(posedge BUS) begin
		if (reset) begin
			read_data <= '0;
			error     <= 1'b0;
		end
		else if (done) begin
			error <= read_err || write_err;             // Held until the next completion
			if (read_ok) begin
				read_data <= read_sel;
			end
		end
	end

endmodule : bus_response_regs

// ==== rtl/bus_wait_timer.sv ====
module bus_wait_timer (
	input  logic BUS,
	input  logic reset,
	input  logic valid,
	input  logic rnw,
	output logic ready,
	output logic done
);
	import gpio_bus_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,                                        // Waiting for valid
		ST_WAIT,                                        // Counting wait states
		ST_RECOVER                                      // Ready cycle with valid ignored at its end
	} state_t;

	state_t      state;
	wait_count_t count;
	wait_count_t target;

	assign target = rnw ? READ_WAIT : WRITE_WAIT;     // Reads take one cycle longer

	// Last wait cycle before ready
	assign done = (state == ST_WAIT) && (count == target);

	//////////////////////////////////////////////////////////////////////
	// State machine

	always_ff @(posedge BUS) begin
		if (reset) begin
			state <= ST_IDLE;
			count <= '0;
			ready <= 1'b0;
		end
		else begin
			ready <= 1'b0;                              // One-cycle pulse by default
			case (state)
				ST_IDLE: begin
					if (valid) begin
						state <= ST_WAIT;
						count <= wait_count_t'(1);      // Accept edge counts as the first
					end
				end
				ST_WAIT: begin
					if (done) begin
						state <= ST_RECOVER;
						ready <= 1'b1;
					end
					else begin
						count <= count + 2'd1;
					end
				end
				default: begin
					state <= ST_IDLE;                   // Master drops valid here
					count <= '0;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks

	ready_one_cycle : assert property (@(posedge BUS) disable iff (reset)
		ready |=> !ready);

	// Wait length must not change under the counter
	rnw_held : assert property (@(posedge BUS) disable iff (reset)
		(state == ST_WAIT) |-> $stable(rnw));

endmodule : bus_wait_timer

// ==== rtl/gpio_addr_decode.sv ====
module gpio_addr_decode (
	input  gpio_bus_pkg::addr_t       addr,
	output gpio_bus_pkg::region_t     region,
	output gpio_bus_pkg::word_index_t word_index
);
	import gpio_bus_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Offsets into each bank

	addr_t gpo_offset;
	addr_t gpi_offset;
	logic  aligned;
	logic  in_gpo;
	logic  in_gpi;

	// Below the base wraps to a large offset, so one compare covers both ends
	assign gpo_offset = addr - GPO_BASE;
	assign gpi_offset = addr - GPI_BASE;

	assign in_gpo  = (gpo_offset < BANK_BYTES);
	assign in_gpi  = (gpi_offset < BANK_BYTES);
	assign aligned = (addr[BYTE_OFFSET_W-1:0] == '0); // Word accesses only

	// Index bits sit just above the byte lanes
	assign word_index = addr[BYTE_OFFSET_W +: $bits(word_index_t)];

	//////////////////////////////////////////////////////////////////////
	// Region select

	always_comb begin
		region = REGION_NONE;                           // Default is a bus error
		if (aligned) begin
			if (in_gpo) begin
				region = REGION_GPO;
			end
			else if (in_gpi) begin
				region = REGION_GPI;
			end
		end
	end

endmodule : gpio_addr_decode

// ==== rtl/gpio_bus_pkg.sv ====
package gpio_bus_pkg;

	//////////////////////////////////////////////////////////////////////
	// Bus widths

	localparam int ADDR_W        = 32;
	localparam int DATA_W        = 32;
	localparam int BYTE_OFFSET_W = 2;                   // Byte lanes inside one word

	typedef logic [ADDR_W-1:0] addr_t;                  // Bus address
	typedef logic [DATA_W-1:0] data_t;                  // Bus data word

	//////////////////////////////////////////////////////////////////////
	// Register map

	localparam int WORD_COUNT = 8;                      // Words per GPIO bank

	typedef logic [$clog2(WORD_COUNT)-1:0] word_index_t;
	typedef logic [WORD_COUNT*DATA_W-1:0]  gpio_vec_t;  // All words of one bank with word 0 lowest

	localparam addr_t GPO_BASE = 32'h0100_0000;         // Read/write output words
	localparam addr_t GPI_BASE = 32'h0100_0020;         // Read-only input words

	// Byte span of one bank
	localparam addr_t BANK_BYTES = addr_t'(WORD_COUNT * (DATA_W / 8));

	// Result of the address decode
	typedef enum logic [1:0] {
		REGION_GPO,
		REGION_GPI,
		REGION_NONE                                     // Unmapped or misaligned
	} region_t;

	//////////////////////////////////////////////////////////////////////
	// Wait states

	typedef logic [1:0] wait_count_t;

	// Counted from the edge that accepts the request
	localparam wait_count_t WRITE_WAIT = 2'd2;
	localparam wait_count_t READ_WAIT  = 2'd3;

endpackage : gpio_bus_pkg

// ==== rtl/gpio_bus_slave.sv ====
module gpio_bus_slave (
	input  logic                                BUS,
	input  logic                                reset,
	input  logic                                valid,
	input  logic                                rnw,
	input  gpio_bus_pkg::addr_t                 addr,
	input  gpio_bus_pkg::data_t                 write_data,
	input  gpio_bus_pkg::gpio_vec_t             gp_ip,
	output logic                                ready,
	output logic                                error,
	output gpio_bus_pkg::data_t                 read_data,
	output gpio_bus_pkg::gpio_vec_t             gp_op,
	output logic [gpio_bus_pkg::WORD_COUNT-1:0] gp_op_valid
);
	import gpio_bus_pkg::*;

	region_t     region;                            // From the decoder
	word_index_t word_index;
	logic        done;                              // Completion strobe in the cycle before ready
	data_t       gpo_word;                          // Output word for readback

	//////////////////////////////////////////////////////////////////////
	// Blocks

	gpio_addr_decode u_decode (
		.addr       (addr),
		.region     (region),
		.word_index (word_index)
	);

	bus_wait_timer u_timer (
		.BUS   (BUS),
		.reset (reset),
		.valid (valid),
		.rnw   (rnw),
		.ready (ready),
		.done  (done)
	);

	gpo_register_bank u_gpo (
		.BUS         (BUS),
		.reset       (reset),
		.done        (done),
		.rnw         (rnw),
		.region      (region),
		.word_index  (word_index),
		.write_data  (write_data),
		.gp_op       (gp_op),
		.gp_op_valid (gp_op_valid),
		.gpo_word    (gpo_word)
	);

	bus_response_regs u_resp (
		.BUS        (BUS),
		.reset      (reset),
		.done       (done),
		.rnw        (rnw),
		.region     (region),
		.word_index (word_index),
		.gpo_word   (gpo_word),
		.gp_ip      (gp_ip),
		.read_data  (read_data),
		.error      (error)
	);

	// The master holds its request until the ready cycle
	request_stable : assert property (@(posedge BUS) disable iff (reset)
		(valid && !ready) |=> (valid && $stable({addr, rnw, write_data})));

endmodule : gpio_bus_slave

// ==== rtl/gpo_register_bank.sv ====
module gpo_register_bank (
	input  logic                                  BUS,
	input  logic                                  reset,
	input  logic                                  done,
	input  logic                                  rnw,
	input  gpio_bus_pkg::region_t                 region,
	input  gpio_bus_pkg::word_index_t             word_index,
	input  gpio_bus_pkg::data_t                   write_data,
	output gpio_bus_pkg::gpio_vec_t               gp_op,
	output logic [gpio_bus_pkg::WORD_COUNT-1:0]   gp_op_valid,
	output gpio_bus_pkg::data_t                   gpo_word
);
	import gpio_bus_pkg::*;

	logic write_hit;

	// Only a completed write to the output bank changes state
	assign write_hit = done && !rnw && (region == REGION_GPO);

	//////////////////////////////////////////////////////////////////////
	// Output words and strobes

	always_ff @(posedge BUS) begin
		if (reset) begin
			gp_op       <= '0;
			gp_op_valid <= '0;
		end
		else begin
			gp_op_valid <= '0;                          // Strobe lasts one cycle
			if (write_hit) begin
				gp_op[word_index*DATA_W +: DATA_W] <= write_data;
				gp_op_valid[word_index]            <= 1'b1; // Lines up with ready
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Readback

	// Readback word that the response registers sample at done
	assign gpo_word = gp_op[word_index*DATA_W +: DATA_W];

	//////////////////////////////////////////////////////////////////////
	// Checks

	// At most one word per transfer
	strobe_onehot : assert property (@(posedge BUS) disable iff (reset)
		$onehot0(gp_op_valid));

endmodule : gpo_register_bank

// ==== sources.f ====
+incdir+tests
rtl/gpio_bus_pkg.sv
rtl/gpio_addr_decode.sv
rtl/bus_wait_timer.sv
rtl/gpo_register_bank.sv
rtl/bus_response_regs.sv
rtl/gpio_bus_slave.sv
tests/gpio_bus_slave_tb.sv

// ==== tests/gpio_bus_tasks.svh ====
//////////////////////////////////////////////////////////////////////
// Reporting

task automatic fail_run();
	$display("Test failed");
	$fatal(1);
endtask

task automatic check_value(input gpio_vec_t got, input gpio_vec_t exp, input string what);
	if (got !== exp) begin
		$display("** Error at time %0t: %s, got 'h%0h, expected 'h%0h",
			$time, what, got, exp);
		fail_run();
	end
endtask

//////////////////////////////////////////////////////////////////////
// Register map model

// Aligned word inside one bank
function automatic logic in_bank(input addr_t a, input addr_t base);
	return (a[1:0] == 2'b00) && (a >= base) && (a < base + BANK_SPAN);
endfunction

function automatic addr_t word_addr(input addr_t base, input word_index_t i);
	return base + {27'd0, i, 2'b00};
endfunction

// One request checked against the model through the whole handshake
task automatic do_transfer(input addr_t a, input logic r, input data_t wd);
	logic                  gpo_hit;
	logic                  gpi_hit;
	word_index_t           idx;
	logic                  exp_err;
	logic [WORD_COUNT-1:0] exp_strobe;
	int                    cycles;

	gpo_hit    = in_bank(a, GPO_BASE);
	gpi_hit    = in_bank(a, GPI_BASE);
	idx        = a[4:2];                            // Word select above the byte lanes
	exp_strobe = '0;
	if (r) begin
		exp_err = !(gpo_hit || gpi_hit);
		if (gpo_hit)
			last_read = gpo_model[idx*DATA_W +: DATA_W];
		else if (gpi_hit)
			last_read = gp_ip[idx*DATA_W +: DATA_W];
	end
	else begin
		exp_err = !gpo_hit;                         // Input bank is read only
		if (gpo_hit) begin
			gpo_model[idx*DATA_W +: DATA_W] = wd;
			exp_strobe[idx]                 = 1'b1;
		end
	end
	valid      = 1'b1;
	addr       = a;
	rnw        = r;
	write_data = wd;
	cycles     = 0;
	do begin
		@(negedge BUS);
		cycles++;
		if (cycles > READY_LIMIT) begin
			$display("No ready for the request to address 'h%h within %0d cycles",
				a, READY_LIMIT);
			fail_run();
		end
		if (!ready)
			check_value(gpio_vec_t'(gp_op_valid), '0, "strobe before ready");
	end while (!ready);
	// The first falling edge follows E0 so edge E0+n shows up as count n+1
	check_value(gpio_vec_t'(cycles - 1), gpio_vec_t'(r ? 3 : 2), "edges from accept to ready");
	check_value(gpio_vec_t'(error), gpio_vec_t'(exp_err), "error flag");
	check_value(gpio_vec_t'(read_data), gpio_vec_t'(last_read), "read data");
	check_value(gpio_vec_t'(gp_op_valid), gpio_vec_t'(exp_strobe), "write strobe");
	check_value(gp_op, gpo_model, "gp_op");
	@(negedge BUS);                                 // Completion cycle is over
	valid = 1'b0;
	check_value(gpio_vec_t'({ready, gp_op_valid}), '0, "ready or strobe past one cycle");
endtask

//////////////////////////////////////////////////////////////////////
// Directed tests

task automatic verify_reset_state();
	check_value(gpio_vec_t'({ready, error, gp_op_valid}), '0, "ready, error, strobe at reset");
	check_value(gp_op, '0, "gp_op at reset");
	check_value(gpio_vec_t'(read_data), '0, "read data at reset");
	for (int i = 0; i < WORD_COUNT; i++)
		do_transfer(word_addr(GPO_BASE, word_index_t'(i)), 1'b1, '0);
endtask

task automatic gpo_write_readback();
	data_t written [WORD_COUNT];

	for (int i = 0; i < WORD_COUNT; i++) begin
		written[i] = $random(seed);
		do_transfer(word_addr(GPO_BASE, word_index_t'(i)), 1'b0, written[i]);
	end
	for (int i = 0; i < WORD_COUNT; i++)
		check_value(gpio_vec_t'(gp_op[i*DATA_W +: DATA_W]), gpio_vec_t'(written[i]),
			"gp_op slice");
	for (int i = 0; i < WORD_COUNT; i++)
		do_transfer(word_addr(GPO_BASE, word_index_t'(i)), 1'b1, '0);
endtask

task automatic gpi_readback();
	for (int i = 0; i < WORD_COUNT; i++)
		gp_ip[i*DATA_W +: DATA_W] = $random(seed);  // Changed while the bus is idle
	for (int i = 0; i < WORD_COUNT; i++)
		do_transfer(word_addr(GPI_BASE, word_index_t'(i)), 1'b1, '0);
endtask

task automatic bus_error_cases();
	gpio_vec_t saved_op;

	saved_op = gpo_model;                                       // Model before the errors
	do_transfer(GPI_BASE, 1'b0, 32'hdead_beef);                 // Input bank write
	do_transfer(GPI_BASE + 32'h1c, 1'b0, 32'h1234_5678);
	do_transfer(32'h0100_0040, 1'b1, '0);                       // Past the last word
	do_transfer(32'h0100_0040, 1'b0, 32'hcafe_f00d);
	do_transfer(GPO_BASE - 32'd4, 1'b1, '0);                    // Below the map
	do_transfer(GPO_BASE - 32'd4, 1'b0, 32'h0bad_0bad);
	do_transfer(GPO_BASE + 32'd2, 1'b0, 32'h5555_aaaa);         // Unaligned
	do_transfer(GPI_BASE + 32'd5, 1'b1, '0);
	check_value(gp_op, saved_op, "gp_op after bus errors");
endtask

// One write and one read of the same word
task automatic latency_spot_check();
	do_transfer(word_addr(GPO_BASE, 3'd5), 1'b0, 32'h5a5a_0005);
	@(negedge BUS);
	do_transfer(word_addr(GPO_BASE, 3'd5), 1'b1, '0);
endtask

task automatic random_traffic();
	int    pick;
	int    idle;
	data_t bits;
	addr_t req_addr;

	for (int n = 0; n < 30; n++) begin
		pick = $unsigned($random(seed)) % 32'd8;
		bits = $random(seed);
		case (pick)
			0, 1, 2: req_addr = word_addr(GPO_BASE, bits[4:2]);
			3, 4:    req_addr = word_addr(GPI_BASE, bits[4:2]);
			5:       req_addr = word_addr(bits[6] ? GPO_BASE : GPI_BASE, bits[4:2])
				+ {30'd0, bits[1:0] | 2'b01};
			6:       req_addr = 32'h0100_0040 + {24'd0, bits[7:2], 2'b00};
			default: req_addr = GPO_BASE - 32'd4 - {24'd0, bits[7:2], 2'b00};
		endcase
		do_transfer(req_addr, bits[8], $random(seed));
		idle = $unsigned($random(seed)) % 32'd4;   // 0 to 3 quiet cycles
		repeat (idle) @(negedge BUS);
	end
endtask

// ==== tests/gpio_bus_slave_tb.sv ====
module gpio_bus_slave_tb;
	import gpio_bus_pkg::*;

	localparam int    CLK_PERIOD   = 20;
	localparam int    RESET_CYCLES = 4;
	localparam int    READY_LIMIT  = 10;              // Edges a request may wait for ready
	localparam addr_t BANK_SPAN    = 32'h20;          // Eight words of four bytes

	// Transfer count summed over the tests in sequence order
	localparam int TXN_COUNT     = 8 + 16 + 8 + 8 + 2 + 30;
	localparam int WATCHDOG_TIME = (TXN_COUNT * 8 + 20) * CLK_PERIOD;

	logic      BUS;
	logic      reset;
	logic      valid;
	logic      rnw;
	addr_t     addr;
	data_t     write_data;
	gpio_vec_t gp_ip;
	logic      ready;
	logic      error;
	data_t     read_data;
	gpio_vec_t gp_op;
	logic [WORD_COUNT-1:0] gp_op_valid;

	gpio_vec_t gpo_model;                             // Expected output words
	data_t     last_read;                             // Expected read_data that errors leave alone
	integer    seed;

	gpio_bus_slave uut (
		.BUS         (BUS),
		.reset       (reset),
		.valid       (valid),
		.rnw         (rnw),
		.addr        (addr),
		.write_data  (write_data),
		.gp_ip       (gp_ip),
		.ready       (ready),
		.error       (error),
		.read_data   (read_data),
		.gp_op       (gp_op),
		.gp_op_valid (gp_op_valid)
	);

	`include "gpio_bus_tasks.svh"

	initial begin
		BUS = 1'b0;
		forever #(CLK_PERIOD / 2) BUS = ~BUS;
	end

	// Hang guard sized from the transfer count
	initial begin
		#(WATCHDOG_TIME);
		$display("Watchdog expired after %0d time units, the bus sequence hung",
			WATCHDOG_TIME);
		fail_run();
	end

	//////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		seed       = 32'h7dca;
		reset      = 1'b1;
		valid      = 1'b0;
		rnw        = 1'b0;
		addr       = '0;
		write_data = '0;
		gp_ip      = '0;
		gpo_model  = '0;
		last_read  = '0;
		repeat (RESET_CYCLES) @(posedge BUS);
		@(negedge BUS);
		reset = 1'b0;                                 // Tasks start on a falling edge
		verify_reset_state();
		gpo_write_readback();
		gpi_readback();
		bus_error_cases();
		latency_spot_check();
		random_traffic();
		$display("Test passed");
		$finish;
	end

endmodule : gpio_bus_slave_tb
